// File: Makefile
VERILATOR = verilator
VFLAGS    = --timing --timescale 1ns/1ns
TOP       = tb_alu
FILELIST  = all.f
OBJ_DIR   = obj_dir

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "sim passed"

clean:
	rm -rf $(OBJ_DIR)

// File: all.f
+incdir+verilog
+incdir+bench
verilog/alu_pkg.sv
verilog/op_decode.sv
verilog/add_sub_unit.sv
verilog/cond_eval.sv
verilog/result_mux.sv
verilog/retire_stage.sv
verilog/alu_top.sv
bench/tb_alu.sv

// File: bench/alu_ref_model.svh
`ifndef ALU_REF_MODEL_SVH
`define ALU_REF_MODEL_SVH

// flag word is C O A S Z P from bit 5 down
function automatic logic cond_holds(input logic [5:0] f, input logic [3:0] cond);
  logic base;
  case (cond & 4'b1110)
    `COND_Z:   base = f[1];
    `COND_S:   base = f[2];
    `COND_UGT: base = !f[5] && !f[1];
    `COND_UGE: base = !f[5];
    `COND_SGT: base = (f[2] == f[4]) && !f[1];
    `COND_SGE: base = f[2] == f[4];
    `COND_O:   base = f[4];
    default:   base = f[0];  // parity
  endcase
  return cond[0] ? !base : base;
endfunction

function automatic logic opcode_legal(input logic [7:0] opc);
  case (opc)
    `OP_ADD64, `OP_ADD32, `OP_SUB64, `OP_SUB32, `OP_AND64, `OP_AND32,
    `OP_OR64, `OP_OR32, `OP_XOR64, `OP_XOR32, `OP_MOV64, `OP_MOV32,
    `OP_ZXT8_64, `OP_ZXT16_64, `OP_SXT8_64, `OP_SXT16_64, `OP_SXT32_64,
    `OP_CMOV64, `OP_CSET: return 1'b1;
    default: return 1'b0;
  endcase
endfunction

// arithmetic and logic ops are the only flag writers
function automatic logic opcode_writes_flags(input logic [7:0] opc);
  return opc inside {`OP_ADD64, `OP_ADD32, `OP_SUB64, `OP_SUB32, `OP_AND64,
                     `OP_AND32, `OP_OR64, `OP_OR32, `OP_XOR64, `OP_XOR32};
endfunction

function automatic logic [63:0] ref_result(input logic [7:0] opc, input logic cond_ok,
                                           input logic [63:0] v1, input logic [63:0] v2);
  logic [31:0] a;
  logic [31:0] b;
  a = v1[31:0];
  b = v2[31:0];
  case (opc)
    `OP_ADD64:    return v1 + v2;
    `OP_ADD32:    return {32'd0, a + b};
    `OP_SUB64:    return v1 - v2;
    `OP_SUB32:    return {32'd0, a - b};
    `OP_AND64:    return v1 & v2;
    `OP_AND32:    return {32'd0, a & b};
    `OP_OR64:     return v1 | v2;
    `OP_OR32:     return {32'd0, a | b};
    `OP_XOR64:    return v1 ^ v2;
    `OP_XOR32:    return {32'd0, a ^ b};
    `OP_MOV64:    return v2;
    `OP_MOV32:    return {32'd0, b};
    `OP_ZXT8_64:  return {56'd0, v2[7:0]};
    `OP_ZXT16_64: return {48'd0, v2[15:0]};
    `OP_SXT8_64:  return 64'($signed(v2[7:0]));
    `OP_SXT16_64: return 64'($signed(v2[15:0]));
    `OP_SXT32_64: return 64'($signed(b));
    `OP_CMOV64:   return cond_ok ? v2 : v1;
    `OP_CSET:     return {63'd0, cond_ok};
    default:      return 64'd0;
  endcase
endfunction

function automatic logic [5:0] ref_flags(input logic [7:0] opc, input logic [63:0] v1,
                                         input logic [63:0] v2, input logic [63:0] r);
  logic w32, sub, arith;
  logic c, o, a, s, z, p;
  logic sa, sb;
  logic [64:0] s65;
  logic [32:0] s33;
  logic [4:0] s5;
  w32 = opc inside {`OP_ADD32, `OP_SUB32, `OP_AND32, `OP_OR32, `OP_XOR32};
  sub = opc inside {`OP_SUB64, `OP_SUB32};
  arith = sub || (opc inside {`OP_ADD64, `OP_ADD32});
  s65 = {1'b0, v1} + {1'b0, v2};
  s33 = {1'b0, v1[31:0]} + {1'b0, v2[31:0]};
  s5 = {1'b0, v1[3:0]} + {1'b0, v2[3:0]};
  sa = w32 ? v1[31] : v1[63];
  sb = w32 ? v2[31] : v2[63];
  s = w32 ? r[31] : r[63];
  z = w32 ? (r[31:0] == 32'd0) : (r == 64'd0);
  p = ~^r[7:0];
  // borrow on sub is an unsigned compare
  c = sub ? (w32 ? v1[31:0] < v2[31:0] : v1 < v2) : (w32 ? s33[32] : s65[64]);
  a = sub ? v1[3:0] < v2[3:0] : s5[4];
  o = sub ? (sa != sb && s != sa) : (sa == sb && s != sa);
  if (!opcode_writes_flags(opc)) begin
    return 6'd0;
  end
  if (!arith) begin
    return {3'b000, s, z, p};
  end
  return {c, o, a, s, z, p};
endfunction

`endif

// File: bench/tb_alu.sv
`timescale 1ns/1ns
`default_nettype none

`include "alu_defs.svh"

module tb_alu;

  localparam int N_OPS = 3000;
  localparam int CYCLE_LIMIT = N_OPS + 50;

  logic clk = 1'b0;
  logic rst;
  logic data_en;
  alu_pkg::op_word_t operation;
  alu_pkg::data_t val1;
  alu_pkg::data_t val2;
  alu_pkg::flags_t flags_in;
  logic thread, except, except_thread;
  alu_pkg::data_t result;
  alu_pkg::flags_t flags;
  logic sets_flags, ret_en;

  int n_checks = 0;
  int n_errors = 0;
  int op_idx = 0;
  int cycle_count = 0;

  // expected outputs of the op in flight
  logic [63:0] exp_result;
  logic [5:0] exp_flags;
  logic exp_sets, exp_ret, exp_valid;
  logic prev_except, prev_except_thread;

  alu_pkg::opcode_t legal_ops [19] = '{
    `OP_ADD64, `OP_ADD32, `OP_SUB64, `OP_SUB32, `OP_AND64, `OP_AND32, `OP_OR64,
    `OP_OR32, `OP_XOR64, `OP_XOR32, `OP_MOV64, `OP_MOV32, `OP_ZXT8_64, `OP_ZXT16_64,
    `OP_SXT8_64, `OP_SXT16_64, `OP_SXT32_64, `OP_CMOV64, `OP_CSET
  };

  `include "alu_ref_model.svh"

  alu_top dut (
    .clk           (clk),
    .rst           (rst),
    .data_en       (data_en),
    .operation     (operation),
    .val1          (val1),
    .val2          (val2),
    .flags_in      (flags_in),
    .thread        (thread),
    .except        (except),
    .except_thread (except_thread),
    .result        (result),
    .flags         (flags),
    .sets_flags    (sets_flags),
    .ret_en        (ret_en)
  );

  always #10 clk = ~clk;

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("** Error %s: got %h, expected %h (op %0d)", name, got, exp, op_idx);
    end
  endtask

  // edge values weighted heavily
  function automatic logic [63:0] pick_operand();
    case ($urandom_range(0, 7))
      0: return 64'd0;
      1: return '1;
      2: return 64'h8000_0000_0000_0000;
      3: return 64'h7fff_ffff_ffff_ffff;
      4: return {$urandom, 32'h8000_0000};
      5: return {$urandom, 32'h7fff_ffff};
      6: return 64'($urandom_range(0, 31));
      default: return {$urandom, $urandom};
    endcase
  endfunction

  task automatic issue_random_op();
    alu_pkg::opcode_t opc;
    alu_pkg::cond_t cond;
    logic noflags, kill;
    int k;
    if ($urandom_range(0, 99) < 3) begin
      do opc = 8'($urandom); while (opcode_legal(opc));
    end else begin
      k = int'($urandom_range(0, 18));
      opc = legal_ops[k];
    end
    cond = 4'($urandom);
    noflags = 1'($urandom);
    data_en = $urandom_range(0, 99) < 80;
    operation = {noflags, cond, opc};
    val1 = pick_operand();
    val2 = pick_operand();
    flags_in = 6'($urandom);
    thread = 1'($urandom);
    except = $urandom_range(0, 99) < 15;
    except_thread = 1'($urandom);
    kill = (except && except_thread == thread) ||
           (prev_except && prev_except_thread == thread);  // this cycle or the last
    prev_except = except;
    prev_except_thread = except_thread;
    exp_valid = data_en;
    exp_result = ref_result(opc, cond_holds(flags_in, cond), val1, val2);
    exp_flags = ref_flags(opc, val1, val2, exp_result);
    exp_sets = data_en && !noflags && opcode_writes_flags(opc);
    exp_ret = data_en && opcode_legal(opc) && !kill;
  endtask

  task automatic compare_outputs();
    check_value("ret_en", 64'(ret_en), 64'(exp_ret));
    check_value("sets_flags", 64'(sets_flags), 64'(exp_sets));
    if (exp_valid) begin
      check_value("result", result, exp_result);
      check_value("flags", 64'(flags), 64'(exp_flags));
    end
  endtask

  initial begin
    while (cycle_count < CYCLE_LIMIT) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
    $display("sim failed");
    $finish;
  end

  initial begin
    void'($urandom(32'h65a6));
    rst = 1'b1;
    data_en = 1'b0;
    operation = '0;
    val1 = '0;
    val2 = '0;
    flags_in = '0;
    thread = 1'b0;
    except = 1'b0;
    except_thread = 1'b0;
    prev_except = 1'b0;
    prev_except_thread = 1'b0;
    repeat (2) @(negedge clk);
    rst = 1'b0;
    // outputs still show the reset state here
    check_value("ret_en", 64'(ret_en), 64'd0);
    check_value("sets_flags", 64'(sets_flags), 64'd0);
    check_value("result", result, 64'd0);
    check_value("flags", 64'(flags), 64'd0);
    for (op_idx = 0; op_idx < N_OPS; op_idx++) begin
      issue_random_op();
      @(negedge clk);
      compare_outputs();  // one cycle latency
    end
    $display("%0d checks, %0d errors", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: verilog/add_sub_unit.sv
`timescale 1ns/1ns
`default_nettype none

module add_sub_unit (
  input  alu_pkg::data_t a,
  input  alu_pkg::data_t b,
  input  logic           sub,
  output alu_pkg::data_t sum,
  output logic           carry4,
  output logic           carry32,
  output logic           carry64
);

  alu_pkg::data_t b_eff;

  assign b_eff = sub ? ~b : b;  // a - b = a + ~b + 1

  assign {carry64, sum} = {1'b0, a} + {1'b0, b_eff} + {64'b0, sub};

  // carry into bit k recovered from the sum bit
  assign carry4  = a[4] ^ b_eff[4] ^ sum[4];
  assign carry32 = a[32] ^ b_eff[32] ^ sum[32];

endmodule

`default_nettype wire

// File: verilog/alu_defs.svh
`ifndef ALU_DEFS_SVH
`define ALU_DEFS_SVH

`define ALU_DATA_W      64
`define ALU_FLAG_W      6   // C O A S Z P, msb first
`define ALU_OP_W        13
`define ALU_OPC_W       8
`define ALU_COND_W      4
`define ALU_COND_LSB    8
`define ALU_NOFLAGS_BIT 12

// opcode field, operation[7:0]
`define OP_ADD64    8'd0
`define OP_ADD32    8'd1
`define OP_SUB64    8'd2
`define OP_SUB32    8'd3
`define OP_AND64    8'd4
`define OP_AND32    8'd5
`define OP_OR64     8'd6
`define OP_OR32     8'd7
`define OP_XOR64    8'd8
`define OP_XOR32    8'd9
`define OP_MOV64    8'd10
`define OP_MOV32    8'd11
`define OP_ZXT8_64  8'd12
`define OP_ZXT16_64 8'd13
`define OP_SXT8_64  8'd14
`define OP_SXT16_64 8'd15
`define OP_SXT32_64 8'd16
`define OP_CMOV64   8'd17
`define OP_CSET     8'd18

// even codes only, bit 0 set means inverted
`define COND_Z   4'd0
`define COND_S   4'd2
`define COND_UGT 4'd4
`define COND_UGE 4'd6
`define COND_SGT 4'd8
`define COND_SGE 4'd10
`define COND_O   4'd12
`define COND_P   4'd14

`endif

// File: verilog/alu_pkg.sv
`default_nettype none

`include "alu_defs.svh"

package alu_pkg;

  typedef logic [`ALU_DATA_W-1:0] data_t;
  typedef logic [`ALU_FLAG_W-1:0] flags_t;
  typedef logic [`ALU_OPC_W-1:0]  opcode_t;
  typedef logic [`ALU_COND_W-1:0] cond_t;
  typedef logic [`ALU_OP_W-1:0]   op_word_t;

  typedef enum logic [2:0] {
    CLS_ADD,
    CLS_LOGIC,
    CLS_MOV,
    CLS_EXT,
    CLS_CMOV,
    CLS_CSET,
    CLS_NONE  // illegal opcode
  } op_class_e;

endpackage

`default_nettype wire

// File: verilog/alu_top.sv
`timescale 1ns/1ns
`default_nettype none

`include "alu_defs.svh"

module alu_top (
  input  logic              clk,
  input  logic              rst,
  input  logic              data_en,
  input  alu_pkg::op_word_t operation,
  input  alu_pkg::data_t    val1,
  input  alu_pkg::data_t    val2,
  input  alu_pkg::flags_t   flags_in,
  input  logic              thread,
  input  logic              except,
  input  logic              except_thread,
  output alu_pkg::data_t    result,
  output alu_pkg::flags_t   flags,
  output logic              sets_flags,
  output logic              ret_en
);

  alu_pkg::op_class_e op_class;
  alu_pkg::opcode_t   opcode;
  alu_pkg::cond_t     cond;
  alu_pkg::data_t     sum;
  alu_pkg::data_t     result_d;
  logic is_32, is_sub, sets_flags_req;
  logic carry4, carry32, carry64;
  logic cond_true;
  logic val1_sign, val2_sign;

  assign opcode = operation[`ALU_OPC_W-1:0];
  assign val1_sign = is_32 ? val1[31] : val1[63];  // sign bit of the op width
  assign val2_sign = is_32 ? val2[31] : val2[63];

  op_decode u_decode (
    .operation      (operation),
    .op_class       (op_class),
    .is_32          (is_32),
    .is_sub         (is_sub),
    .cond           (cond),
    .sets_flags_req (sets_flags_req)
  );

  add_sub_unit u_add (
    .a       (val1),
    .b       (val2),
    .sub     (is_sub),
    .sum     (sum),
    .carry4  (carry4),
    .carry32 (carry32),
    .carry64 (carry64)
  );

  cond_eval u_cond (
    .flags     (flags_in),
    .cond      (cond),
    .cond_true (cond_true)
  );

  result_mux u_mux (
    .op_class  (op_class),
    .opcode    (opcode),
    .is_32     (is_32),
    .val1      (val1),
    .val2      (val2),
    .sum       (sum),
    .cond_true (cond_true),
    .result    (result_d)
  );

  retire_stage u_retire (
    .clk            (clk),
    .rst            (rst),
    .data_en        (data_en),
    .thread         (thread),
    .except         (except),
    .except_thread  (except_thread),
    .op_class       (op_class),
    .is_32          (is_32),
    .is_sub         (is_sub),
    .sets_flags_req (sets_flags_req),
    .result_d       (result_d),
    .val1_sign      (val1_sign),
    .val2_sign      (val2_sign),
    .carry4         (carry4),
    .carry32        (carry32),
    .carry64        (carry64),
    .result         (result),
    .flags          (flags),
    .sets_flags     (sets_flags),
    .ret_en         (ret_en)
  );

endmodule

`default_nettype wire

// File: verilog/cond_eval.sv
`timescale 1ns/1ns
`default_nettype none

`include "alu_defs.svh"

module cond_eval (
  input  alu_pkg::flags_t flags,
  input  alu_pkg::cond_t  cond,
  output logic            cond_true
);

  logic c_f, o_f, s_f, z_f, p_f;
  logic base;

  assign {c_f, o_f} = flags[5:4];  // aux carry in bit 3 has no condition
  assign {s_f, z_f, p_f} = flags[2:0];

  always_comb begin
    case ({cond[3:1], 1'b0})
      `COND_Z:   base = z_f;
      `COND_S:   base = s_f;
      `COND_UGT: base = ~(c_f | z_f);
      `COND_UGE: base = ~c_f;
      `COND_SGT: base = ~((s_f ^ o_f) | z_f);
      `COND_SGE: base = ~(s_f ^ o_f);
      `COND_O:   base = o_f;
      `COND_P:   base = p_f;
      default:   base = 1'b0;
    endcase
  end

  assign cond_true = base ^ cond[0];  // odd codes invert

endmodule

`default_nettype wire

// File: verilog/op_decode.sv
`timescale 1ns/1ns
`default_nettype none

`include "alu_defs.svh"

module op_decode (
  input  alu_pkg::op_word_t  operation,
  output alu_pkg::op_class_e op_class,
  output logic               is_32,
  output logic               is_sub,
  output alu_pkg::cond_t     cond,
  output logic               sets_flags_req
);

  alu_pkg::opcode_t opc;

  assign opc = operation[`ALU_OPC_W-1:0];

  always_comb begin
    op_class = alu_pkg::CLS_NONE;
    is_32 = 1'b0;
    is_sub = 1'b0;
    case (opc)
      `OP_ADD64: op_class = alu_pkg::CLS_ADD;
      `OP_ADD32: begin
        op_class = alu_pkg::CLS_ADD;
        is_32 = 1'b1;
      end
      `OP_SUB64: begin
        op_class = alu_pkg::CLS_ADD;
        is_sub = 1'b1;
      end
      `OP_SUB32: begin
        op_class = alu_pkg::CLS_ADD;
        is_sub = 1'b1;
        is_32 = 1'b1;
      end
      `OP_AND64, `OP_OR64, `OP_XOR64: op_class = alu_pkg::CLS_LOGIC;
      `OP_AND32, `OP_OR32, `OP_XOR32: begin
        op_class = alu_pkg::CLS_LOGIC;
        is_32 = 1'b1;
      end
      `OP_MOV64: op_class = alu_pkg::CLS_MOV;
      `OP_MOV32: begin
        op_class = alu_pkg::CLS_MOV;
        is_32 = 1'b1;
      end
      `OP_ZXT8_64, `OP_ZXT16_64, `OP_SXT8_64, `OP_SXT16_64, `OP_SXT32_64:
        op_class = alu_pkg::CLS_EXT;
      `OP_CMOV64: op_class = alu_pkg::CLS_CMOV;
      `OP_CSET:   op_class = alu_pkg::CLS_CSET;
      default:    op_class = alu_pkg::CLS_NONE;
    endcase
  end

  assign cond = operation[`ALU_COND_LSB +: `ALU_COND_W];

  // only add/sub and logic ops write flags, bit 12 suppresses
  assign sets_flags_req = ~operation[`ALU_NOFLAGS_BIT] &&
    (op_class == alu_pkg::CLS_ADD || op_class == alu_pkg::CLS_LOGIC);

endmodule

`default_nettype wire

// File: verilog/result_mux.sv
`timescale 1ns/1ns
`default_nettype none

`include "alu_defs.svh"

module result_mux (
  input  alu_pkg::op_class_e op_class,
  input  alu_pkg::opcode_t   opcode,
  input  logic               is_32,
  input  alu_pkg::data_t     val1,
  input  alu_pkg::data_t     val2,
  input  alu_pkg::data_t     sum,
  input  logic               cond_true,
  output alu_pkg::data_t     result
);

  alu_pkg::data_t wide;

  always_comb begin
    wide = '0;
    case (op_class)
      alu_pkg::CLS_ADD: wide = sum;
      alu_pkg::CLS_LOGIC: begin
        case (opcode)
          `OP_AND64, `OP_AND32: wide = val1 & val2;
          `OP_OR64, `OP_OR32:   wide = val1 | val2;
          default:              wide = val1 ^ val2;
        endcase
      end
      alu_pkg::CLS_MOV: wide = val2;
      alu_pkg::CLS_EXT: begin
        case (opcode)
          `OP_ZXT8_64:  wide = {56'b0, val2[7:0]};
          `OP_ZXT16_64: wide = {48'b0, val2[15:0]};
          `OP_SXT8_64:  wide = {{56{val2[7]}}, val2[7:0]};
          `OP_SXT16_64: wide = {{48{val2[15]}}, val2[15:0]};
          default:      wide = {{32{val2[31]}}, val2[31:0]};  // sxt32
        endcase
      end
      alu_pkg::CLS_CMOV: wide = cond_true ? val2 : val1;
      alu_pkg::CLS_CSET: wide = {63'b0, cond_true};
      default: wide = '0;
    endcase
  end

  // 32-bit forms clear the upper half
  assign result = is_32 ? {32'b0, wide[31:0]} : wide;

endmodule

`default_nettype wire

// File: verilog/retire_stage.sv
`timescale 1ns/1ns
`default_nettype none

module retire_stage (
  input  logic               clk,
  input  logic               rst,
  input  logic               data_en,
  input  logic               thread,
  input  logic               except,
  input  logic               except_thread,
  input  alu_pkg::op_class_e op_class,
  input  logic               is_32,
  input  logic               is_sub,
  input  logic               sets_flags_req,
  input  alu_pkg::data_t     result_d,
  input  logic               val1_sign,
  input  logic               val2_sign,
  input  logic               carry4,
  input  logic               carry32,
  input  logic               carry64,
  output alu_pkg::data_t     result,
  output alu_pkg::flags_t    flags,
  output logic               sets_flags,
  output logic               ret_en
);

  alu_pkg::op_class_e class_q;
  logic is_32_q, is_sub_q;
  logic carry4_q, carry32_q, carry64_q;
  logic val1_sign_q, val2_sign_q;
  logic except_q, except_thread_q;
  logic kill;
  logic c_f, o_f, a_f, s_f, z_f, p_f;
  logic arith, logic_op;

  // same-thread exception now or one cycle back
  assign kill = (except && except_thread == thread) ||
                (except_q && except_thread_q == thread);

  always_ff @(posedge clk) begin
    if (rst) begin
      result <= '0;
      class_q <= alu_pkg::CLS_NONE;
      is_32_q <= 1'b0;
      is_sub_q <= 1'b0;
      sets_flags <= 1'b0;
      ret_en <= 1'b0;
      except_q <= 1'b0;
      except_thread_q <= 1'b0;
    end else begin
      result <= result_d;
      class_q <= op_class;
      is_32_q <= is_32;
      is_sub_q <= is_sub;
      sets_flags <= data_en && sets_flags_req;
      ret_en <= data_en && op_class != alu_pkg::CLS_NONE && !kill;
      except_q <= except;
      except_thread_q <= except_thread;
    end
  end

  always_ff @(posedge clk) begin
    carry4_q <= carry4;
    carry32_q <= carry32;
    carry64_q <= carry64;
    val1_sign_q <= val1_sign;
    val2_sign_q <= val2_sign;
  end

  assign arith = class_q == alu_pkg::CLS_ADD;
  assign logic_op = class_q == alu_pkg::CLS_LOGIC;

  assign c_f = arith && ((is_32_q ? carry32_q : carry64_q) ^ is_sub_q);  // borrow on sub
  assign a_f = arith && (carry4_q ^ is_sub_q);
  assign s_f = is_32_q ? result[31] : result[63];
  // operands agree in sign (b inverted for sub), result does not
  assign o_f = arith && (val1_sign_q == (val2_sign_q ^ is_sub_q)) && (s_f != val1_sign_q);
  assign z_f = is_32_q ? (result[31:0] == 32'b0) : (result == '0);
  assign p_f = ~^result[7:0];

  assign flags = (arith || logic_op) ? {c_f, o_f, a_f, s_f, z_f, p_f} : '0;

endmodule

`default_nettype wire
